/* include/issue_config.svh */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Datapath widths
`define XLEN      32 // Data and address word
`define TAG_WIDTH 4  // ROB index

// Program counter after reset
`define RESET_PC 32'h0000_0000

// RV32I major opcodes kept by the front end
`define OPC_OP    7'b0110011 // Register-register ALU
`define OPC_OPIMM 7'b0010011 // Register-immediate ALU
`define OPC_LUI   7'b0110111 // Load upper immediate
`define OPC_AUIPC 7'b0010111 // Add upper immediate to PC

// Bit 5 of funct7 selects SUB and SRA
`define FUNCT7_ALT_BIT 5

`endif

/* design/issuePkg.sv */
`include "issue_config.svh"

package issuePkg;

  // Data or address word
  typedef logic [`XLEN-1:0] word_t;

  // Reorder buffer index that doubles as the rename tag
  typedef logic [`TAG_WIDTH-1:0] tag_t;

  // Architectural register number
  typedef logic [4:0] regIdx_t;

  // Reservation station operation codes
  // The gap at 8 and 9 is left for the compare-equal ops of the branch unit
  typedef enum logic [3:0] {
    RS_ADD  = 4'b0000,
    RS_SUB  = 4'b0001,
    RS_XOR  = 4'b0010,
    RS_OR   = 4'b0011,
    RS_AND  = 4'b0100,
    RS_SLL  = 4'b0101,
    RS_SRL  = 4'b0110,
    RS_SRA  = 4'b0111,
    RS_SLT  = 4'b1010,
    RS_SLTU = 4'b1011
  } rsOp_t;

endpackage

/* design/fetchControl.sv */
`timescale 1ns/1ps
`include "issue_config.svh"

module fetchControl import issuePkg::*; (
  input  logic  clockIn,
  input  logic  arstN,
  input  logic  instrValid,    // Fetch side offers an instruction
  output logic  instrReady,    // Fetch register can take it
  input  word_t instrData,
  output word_t instrAddr,
  input  logic  robAllocReady,
  input  logic  rsAddReady,
  input  logic  needsRs,       // Fetch-register instruction uses the RS
  input  logic  isSupported,   // Fetch-register instruction is issued at all
  output word_t fetchedInstr,
  output word_t fetchedPc,
  output logic  issueLoad,     // Fetch register moves into the issue stage
  output logic  issueAdvance,  // Issue entry leaves this cycle
  output logic  issueValid
);

  word_t pcReg;
  word_t fetchInstrReg;
  word_t fetchPcReg;
  logic  fetchValidReg;
  logic  issueValidReg;
  logic  issueNeedsRs;     // RS need of the entry now held in issue

  logic  issueFree;
  logic  fetchDrop;
  logic  fetchMove;
  logic  fetchFire;

  // Leaving takes a ROB slot and an RS slot only if the entry needs one
  assign issueAdvance = issueValidReg && robAllocReady && (!issueNeedsRs || rsAddReady);
  assign issueFree    = !issueValidReg || issueAdvance;

  // Unsupported opcodes are consumed here and never reach the issue stage
  assign fetchDrop = fetchValidReg && !isSupported;
  assign issueLoad = fetchValidReg && isSupported && issueFree;
  assign fetchMove = fetchDrop || issueLoad;

  assign instrReady = !fetchValidReg || fetchMove;
  assign fetchFire  = instrValid && instrReady;

  assign instrAddr    = pcReg;
  assign fetchedInstr = fetchInstrReg;
  assign fetchedPc    = fetchPcReg;
  assign issueValid   = issueValidReg;

  always_ff @(posedge clockIn or negedge arstN) begin
    if (!arstN) begin
      pcReg         <= `RESET_PC;
      fetchValidReg <= 1'b0;
      issueValidReg <= 1'b0;
      issueNeedsRs  <= 1'b0;
    end else begin
      if (fetchFire) begin
        pcReg <= pcReg + 32'd4; // Straight-line fetch only
      end

      if (fetchFire) begin
        fetchValidReg <= 1'b1;
      end else if (fetchMove) begin
        fetchValidReg <= 1'b0;
      end

      if (issueLoad) begin
        issueValidReg <= 1'b1;
        issueNeedsRs  <= needsRs;
      end else if (issueAdvance) begin
        issueValidReg <= 1'b0;
      end
    end
  end

  // Fetch payload
  always_ff @(posedge clockIn) begin
    if (fetchFire) begin
      fetchInstrReg <= instrData;
      fetchPcReg    <= pcReg;
    end
  end

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps
`include "issue_config.svh"

module instrDecoder import issuePkg::*; (
  input  logic    clockIn,
  input  logic    arstN,
  input  word_t   fetchedInstr,
  input  word_t   fetchedPc,
  input  logic    issueLoad,
  input  tag_t    robNext,        // ROB slot offered for the next entry
  output logic    needsRs,        // Fetch-register view
  output logic    isSupported,
  output rsOp_t   rsAddOp,
  output tag_t    rsAddRobIndex,
  output regIdx_t robAddDest,
  output word_t   robAddValue,
  output logic    robAddDone,
  output logic    needsRsHeld,    // Issue-stage view
  output logic    rfUpdateValid,  // Held rename flag
  output regIdx_t srcIdx1,
  output regIdx_t srcIdx2,
  output logic    useImm,
  output word_t   immValue
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7Alt;
  regIdx_t    rd;

  logic isOp;
  logic isOpImm;
  logic isLui;
  logic isAuipc;

  word_t iImm;
  word_t shamt;
  word_t upperImm;
  word_t decValue;
  rsOp_t decOp;

  assign opcode    = fetchedInstr[6:0];
  assign rd        = fetchedInstr[11:7];
  assign funct3    = fetchedInstr[14:12];
  assign funct7Alt = fetchedInstr[25 + `FUNCT7_ALT_BIT];
  assign srcIdx1   = fetchedInstr[19:15];
  assign srcIdx2   = fetchedInstr[24:20];

  assign isOp    = (opcode == `OPC_OP);
  assign isOpImm = (opcode == `OPC_OPIMM);
  assign isLui   = (opcode == `OPC_LUI);
  assign isAuipc = (opcode == `OPC_AUIPC);

  assign isSupported = isOp || isOpImm || isLui || isAuipc;
  assign needsRs     = isOp || isOpImm;

  assign iImm     = {{20{fetchedInstr[31]}}, fetchedInstr[31:20]};
  assign shamt    = {27'b0, fetchedInstr[24:20]};
  assign upperImm = {fetchedInstr[31:12], 12'b0};

  // SLTIU sign-extends too, then compares unsigned
  assign useImm   = isOpImm;
  assign immValue = (funct3 == 3'b001 || funct3 == 3'b101) ? shamt : iImm;

  // Finished result for the upper-immediate group
  always_comb begin
    if (isLui) begin
      decValue = upperImm;
    end else if (isAuipc) begin
      decValue = fetchedPc + upperImm;
    end else begin
      decValue = '0; // Filled in later by the RS result
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  decOp = (isOp && funct7Alt) ? RS_SUB : RS_ADD; // No SUBI
      3'b001:  decOp = RS_SLL;
      3'b010:  decOp = RS_SLT;
      3'b011:  decOp = RS_SLTU;
      3'b100:  decOp = RS_XOR;
      3'b101:  decOp = funct7Alt ? RS_SRA : RS_SRL;
      3'b110:  decOp = RS_OR;
      default: decOp = RS_AND;
    endcase
  end

  // Entry flags
  always_ff @(posedge clockIn or negedge arstN) begin
    if (!arstN) begin
      needsRsHeld   <= 1'b0;
      rfUpdateValid <= 1'b0;
      robAddDone    <= 1'b0;
    end else if (issueLoad) begin
      needsRsHeld   <= needsRs;
      rfUpdateValid <= (rd != 5'd0); // x0 is never renamed
      robAddDone    <= isLui || isAuipc;
    end
  end

  // Entry payload
  always_ff @(posedge clockIn) begin
    if (issueLoad) begin
      rsAddOp       <= decOp;
      rsAddRobIndex <= robNext;
      robAddDest    <= rd;
      robAddValue   <= decValue;
    end
  end

endmodule

/* design/operandResolver.sv */
`timescale 1ns/1ps

module operandResolver import issuePkg::*; (
  input  logic  clockIn,
  input  logic  arstN,
  input  logic  issueLoad,
  input  logic  src1Dirty,
  input  tag_t  src1Tag,
  input  word_t src1Value,
  input  logic  src2Dirty,
  input  tag_t  src2Tag,
  input  word_t src2Value,
  input  logic  useImm,
  input  word_t immValue,
  input  logic  cdbValid,
  input  tag_t  cdbTag,
  input  word_t cdbValue,
  output word_t rsAddVal1,
  output logic  rsAddHasDep1,
  output tag_t  rsAddTag1,
  output word_t rsAddVal2,
  output logic  rsAddHasDep2,
  output tag_t  rsAddTag2
);

  logic  srcDirty [2];
  tag_t  srcTag   [2];
  word_t srcValue [2];
  logic  bypassHit[2];  // Register waits on the tag now on the bus

  word_t valReg   [2];
  logic  depReg   [2];
  tag_t  tagReg   [2];

  assign srcDirty[0] = src1Dirty;
  assign srcTag[0]   = src1Tag;
  assign srcValue[0] = src1Value;
  assign srcDirty[1] = src2Dirty && !useImm;  // Immediate never waits
  assign srcTag[1]   = src2Tag;
  assign srcValue[1] = useImm ? immValue : src2Value;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      bypassHit[i] = cdbValid && (srcTag[i] == cdbTag);
    end
  end

  always_ff @(posedge clockIn or negedge arstN) begin
    if (!arstN) begin
      depReg[0] <= 1'b0;
      depReg[1] <= 1'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (issueLoad) begin
          depReg[i] <= srcDirty[i] && !bypassHit[i];
        end else if (depReg[i] && cdbValid && (tagReg[i] == cdbTag)) begin
          depReg[i] <= 1'b0; // Result arrived while waiting
        end
      end
    end
  end

  always_ff @(posedge clockIn) begin
    for (int i = 0; i < 2; i++) begin
      if (issueLoad) begin
        tagReg[i] <= srcTag[i];
        if (!srcDirty[i]) begin
          valReg[i] <= srcValue[i];
        end else if (bypassHit[i]) begin
          valReg[i] <= cdbValue;
        end else begin
          valReg[i] <= '0;
        end
      end else if (depReg[i] && cdbValid && (tagReg[i] == cdbTag)) begin
        valReg[i] <= cdbValue;
      end
    end
  end

  assign rsAddVal1    = valReg[0];
  assign rsAddHasDep1 = depReg[0];
  assign rsAddTag1    = tagReg[0];
  assign rsAddVal2    = valReg[1];
  assign rsAddHasDep2 = depReg[1];
  assign rsAddTag2    = tagReg[1];

endmodule

/* design/issueUnit.sv */
`timescale 1ns/1ps

module issueUnit import issuePkg::*; (
  input  logic    clockIn,
  input  logic    arstN,
  // Instruction fetch
  input  logic    instrValid,
  output logic    instrReady,
  input  word_t   instrData,
  output word_t   instrAddr,
  // Reorder buffer
  input  logic    robAllocReady,
  input  tag_t    robNext,
  output logic    robAddValid,
  output tag_t    robAddIndex,
  output regIdx_t robAddDest,
  output word_t   robAddValue,
  output logic    robAddDone,
  // Reservation station
  input  logic    rsAddReady,
  output logic    rsAddValid,
  output rsOp_t   rsAddOp,
  output tag_t    rsAddRobIndex,
  output word_t   rsAddVal1,
  output logic    rsAddHasDep1,
  output tag_t    rsAddTag1,
  output word_t   rsAddVal2,
  output logic    rsAddHasDep2,
  output tag_t    rsAddTag2,
  // Result bus
  input  logic    cdbValid,
  input  tag_t    cdbTag,
  input  word_t   cdbValue,
  // Register file
  output regIdx_t srcIdx1,
  output regIdx_t srcIdx2,
  input  logic    src1Dirty,
  input  tag_t    src1Tag,
  input  word_t   src1Value,
  input  logic    src2Dirty,
  input  tag_t    src2Tag,
  input  word_t   src2Value,
  output logic    rfUpdateValid,
  output regIdx_t rfUpdateDest,
  output tag_t    rfUpdateRobId
);

  word_t fetchedInstr;
  word_t fetchedPc;
  logic  issueLoad;
  logic  issueValid;
  logic  needsRs;
  logic  isSupported;
  logic  needsRsHeld;
  logic  renameHeld;
  logic  useImm;
  word_t immValue;

  fetchControl fetchControl_inst (
    .clockIn       (clockIn),
    .arstN         (arstN),
    .instrValid    (instrValid),
    .instrReady    (instrReady),
    .instrData     (instrData),
    .instrAddr     (instrAddr),
    .robAllocReady (robAllocReady),
    .rsAddReady    (rsAddReady),
    .needsRs       (needsRs),
    .isSupported   (isSupported),
    .fetchedInstr  (fetchedInstr),
    .fetchedPc     (fetchedPc),
    .issueLoad     (issueLoad),
    .issueAdvance  (),
    .issueValid    (issueValid)
  );

  instrDecoder instrDecoder_inst (
    .clockIn       (clockIn),
    .arstN         (arstN),
    .fetchedInstr  (fetchedInstr),
    .fetchedPc     (fetchedPc),
    .issueLoad     (issueLoad),
    .robNext       (robNext),
    .needsRs       (needsRs),
    .isSupported   (isSupported),
    .rsAddOp       (rsAddOp),
    .rsAddRobIndex (rsAddRobIndex),
    .robAddDest    (robAddDest),
    .robAddValue   (robAddValue),
    .robAddDone    (robAddDone),
    .needsRsHeld   (needsRsHeld),
    .rfUpdateValid (renameHeld),
    .srcIdx1       (srcIdx1),
    .srcIdx2       (srcIdx2),
    .useImm        (useImm),
    .immValue      (immValue)
  );

  operandResolver operandResolver_inst (
    .clockIn      (clockIn),
    .arstN        (arstN),
    .issueLoad    (issueLoad),
    .src1Dirty    (src1Dirty),
    .src1Tag      (src1Tag),
    .src1Value    (src1Value),
    .src2Dirty    (src2Dirty),
    .src2Tag      (src2Tag),
    .src2Value    (src2Value),
    .useImm       (useImm),
    .immValue     (immValue),
    .cdbValid     (cdbValid),
    .cdbTag       (cdbTag),
    .cdbValue     (cdbValue),
    .rsAddVal1    (rsAddVal1),
    .rsAddHasDep1 (rsAddHasDep1),
    .rsAddTag1    (rsAddTag1),
    .rsAddVal2    (rsAddVal2),
    .rsAddHasDep2 (rsAddHasDep2),
    .rsAddTag2    (rsAddTag2)
  );

  // Held flags only count while an entry sits in issue
  assign robAddValid   = issueValid;
  assign rsAddValid    = issueValid && needsRsHeld;
  assign rfUpdateValid = issueValid && renameHeld;
  assign robAddIndex   = rsAddRobIndex;
  assign rfUpdateRobId = rsAddRobIndex;
  assign rfUpdateDest  = robAddDest;

endmodule

/* test/issueUnit_props.sv */
`timescale 1ns/1ps
`include "issue_config.svh"

module issueUnitProps import issuePkg::*; (
  input logic    clockIn,
  input logic    arstN,
  input word_t   instrAddr,
  input logic    instrReady,
  input logic    robAllocReady,
  input logic    rsAddReady,
  input logic    robAddValid,
  input logic    rsAddValid,
  input logic    rfUpdateValid,
  input rsOp_t   rsAddOp,
  input tag_t    robAddIndex,
  input regIdx_t robAddDest,
  input word_t   robAddValue,
  input logic    robAddDone,
  input word_t   rsAddVal1,
  input logic    rsAddHasDep1,
  input word_t   rsAddVal2,
  input logic    rsAddHasDep2
);

  int   propFailCount = 0;
  logic waiting;  // Entry held but not leaving this edge

  assign waiting = robAddValid && !(robAllocReady && (!rsAddValid || rsAddReady));

  resetState: assert property (@(posedge clockIn) !arstN |->
      instrAddr == `RESET_PC && !robAddValid && !rsAddValid && !rfUpdateValid && instrReady)
    else begin
      propFailCount++;
      $error("Outputs not in reset state while arstN is low");
    end

  entryHolds: assert property (@(posedge clockIn) disable iff (!arstN)
      waiting |=> robAddValid && $stable(rsAddValid) && $stable(rsAddOp)
        && $stable(robAddIndex) && $stable(robAddDest) && $stable(robAddValue)
        && $stable(robAddDone) && $stable(rfUpdateValid))
    else begin
      propFailCount++;
      $error("Issue entry changed while waiting to leave");
    end

  // A resolved operand never goes back to waiting
  operand1Holds: assert property (@(posedge clockIn) disable iff (!arstN)
      waiting && !rsAddHasDep1 |=> !rsAddHasDep1 && $stable(rsAddVal1))
    else begin
      propFailCount++;
      $error("Resolved operand 1 changed while waiting");
    end

  operand2Holds: assert property (@(posedge clockIn) disable iff (!arstN)
      waiting && !rsAddHasDep2 |=> !rsAddHasDep2 && $stable(rsAddVal2))
    else begin
      propFailCount++;
      $error("Resolved operand 2 changed while waiting");
    end

endmodule

/* test/issueUnitTb.sv */
`timescale 1ns/1ps
`include "issue_config.svh"

module issueUnitTb import issuePkg::*; ();

  localparam int NUM_INSTR = 300;

  logic    clockIn, arstN, instrValid, instrReady, robAllocReady, rsAddReady;
  logic    robAddValid, robAddDone, rsAddValid, rsAddHasDep1, rsAddHasDep2;
  logic    cdbValid, src1Dirty, src2Dirty, rfUpdateValid;
  word_t   instrData, instrAddr, robAddValue, rsAddVal1, rsAddVal2, cdbValue;
  word_t   src1Value, src2Value;
  tag_t    robNext, robAddIndex, rsAddRobIndex, rsAddTag1, rsAddTag2, cdbTag;
  tag_t    src1Tag, src2Tag, rfUpdateRobId;
  regIdx_t robAddDest, srcIdx1, srcIdx2, rfUpdateDest;
  rsOp_t   rsAddOp;

  // Register file model with x0 always clean
  logic    regDirty [32];
  tag_t    regTag   [32];
  word_t   regValue [32];

  word_t   progQ    [$];  // Instructions not yet fetched
  word_t   fetchQ   [$];  // Fetch register contents
  word_t   fetchPcQ [$];
  word_t   pcModel;
  logic    fetchAccepted;
  logic    issueOcc;
  int      expectedIssues;
  int      issuedCount;
  int      errorCount;
  int      totalErrors;

  // Expected issue-stage entry
  rsOp_t   expOp;
  logic    expNeedsRs, expDone, expRename, expDep1, expDep2;
  regIdx_t expDest;
  tag_t    expIndex, expTag1, expTag2;
  word_t   expValue, expVal1, expVal2;

  issueUnit issueUnit_inst (.*);

  bind issueUnit issueUnitProps issueUnitProps_inst (.*);

  always #50 clockIn = ~clockIn;

  function automatic logic isIssued(word_t instr);
    return instr[6:0] == `OPC_OP || instr[6:0] == `OPC_OPIMM
      || instr[6:0] == `OPC_LUI || instr[6:0] == `OPC_AUIPC;
  endfunction

  function automatic rsOp_t expectedOp(logic [2:0] f3, logic alt, logic isReg);
    case (f3)
      3'b000:  return (isReg && alt) ? RS_SUB : RS_ADD;
      3'b001:  return RS_SLL;
      3'b010:  return RS_SLT;
      3'b011:  return RS_SLTU;
      3'b100:  return RS_XOR;
      3'b101:  return alt ? RS_SRA : RS_SRL;
      3'b110:  return RS_OR;
      default: return RS_AND;
    endcase
  endfunction

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h",
        $time, name, expected, actual);
    end
  endtask

  task automatic buildProgram();
    word_t      instr;
    logic [2:0] f3;
    logic       alt;
    regIdx_t    rd;
    int         kind;
    for (int i = 0; i < NUM_INSTR; i++) begin
      kind  = $urandom % 10;
      f3    = 3'($urandom);
      rd    = (($urandom % 8) == 0) ? 5'd0 : regIdx_t'($urandom);
      alt   = (f3 == 3'b000 || f3 == 3'b101) ? 1'($urandom) : 1'b0;
      instr = $urandom;
      if (kind < 4) begin
        instr = {1'b0, alt, 5'b0, instr[24:15], f3, rd, `OPC_OP};
      end else if (kind < 7 && (f3 == 3'b001 || f3 == 3'b101)) begin
        instr = {1'b0, alt, 5'b0, instr[24:15], f3, rd, `OPC_OPIMM}; // Shift by shamt
      end else if (kind < 7) begin
        instr = {instr[31:15], f3, rd, `OPC_OPIMM};
      end else if (kind == 7) begin
        instr = {instr[31:12], rd, `OPC_LUI};
      end else if (kind == 8) begin
        instr = {instr[31:12], rd, `OPC_AUIPC};
      end else begin
        instr = {instr[31:7], 7'b0000011}; // Load opcode is consumed without issue
      end
      if (kind < 9) begin
        expectedIssues++;
      end
      progQ.push_back(instr);
    end
  endtask

  // Clean value, same-cycle bypass, or wait on the tag
  task automatic resolveSource(input regIdx_t idx, output logic dep, output tag_t tag,
                               output word_t val);
    tag = regTag[idx];
    dep = regDirty[idx] && !(cdbValid && cdbTag == regTag[idx]);
    val = regDirty[idx] ? cdbValue : regValue[idx];
  endtask

  task automatic loadEntry(input word_t instr, input word_t pc);
    logic [2:0] f3;
    word_t      imm;
    f3         = instr[14:12];
    expNeedsRs = instr[6:0] == `OPC_OP || instr[6:0] == `OPC_OPIMM;
    expDone    = !expNeedsRs;
    expDest    = instr[11:7];
    expRename  = instr[11:7] != 5'd0;
    expIndex   = robNext;
    expOp      = expectedOp(f3, instr[30], instr[6:0] == `OPC_OP);
    expValue   = {instr[31:12], 12'b0};
    if (instr[6:0] == `OPC_AUIPC) begin
      expValue = pc + expValue;
    end
    if (f3 == 3'b001 || f3 == 3'b101) begin
      imm = {27'b0, instr[24:20]};
    end else begin
      imm = {{20{instr[31]}}, instr[31:20]};
    end
    resolveSource(instr[19:15], expDep1, expTag1, expVal1);
    if (instr[6:0] == `OPC_OPIMM) begin
      expDep2 = 1'b0;
      expVal2 = imm;
    end else begin
      resolveSource(instr[24:20], expDep2, expTag2, expVal2);
    end
  endtask

  task automatic compareEntry();
    checkValue("robAddIndex", 32'(expIndex), 32'(robAddIndex));
    checkValue("rfUpdateRobId", 32'(expIndex), 32'(rfUpdateRobId));
    checkValue("robAddDest", 32'(expDest), 32'(robAddDest));
    checkValue("rfUpdateDest", 32'(expDest), 32'(rfUpdateDest));
    checkValue("rfUpdateValid", 32'(expRename), 32'(rfUpdateValid));
    checkValue("robAddDone", 32'(expDone), 32'(robAddDone));
    if (expDone) begin
      checkValue("robAddValue", expValue, robAddValue);
    end else begin
      checkValue("rsAddOp", 32'(expOp), 32'(rsAddOp));
      checkValue("rsAddRobIndex", 32'(expIndex), 32'(rsAddRobIndex));
      checkValue("rsAddHasDep1", 32'(expDep1), 32'(rsAddHasDep1));
      checkValue("rsAddHasDep2", 32'(expDep2), 32'(rsAddHasDep2));
      if (expDep1) checkValue("rsAddTag1", 32'(expTag1), 32'(rsAddTag1));
      else checkValue("rsAddVal1", expVal1, rsAddVal1);
      if (expDep2) checkValue("rsAddTag2", 32'(expTag2), 32'(rsAddTag2));
      else checkValue("rsAddVal2", expVal2, rsAddVal2);
    end
    issuedCount++;
  endtask

  // Reference model step on each rising edge with the inputs of the cycle before
  task automatic stepModel();
    logic leave;
    logic load;
    logic move;
    leave = issueOcc && robAllocReady && (!expNeedsRs || rsAddReady);
    load  = 1'b0;
    move  = 1'b0;
    if (fetchQ.size() != 0) begin
      load = isIssued(fetchQ[0]) && (!issueOcc || leave);
      move = load || !isIssued(fetchQ[0]);
    end
    checkValue("instrAddr", pcModel, instrAddr);
    checkValue("instrReady", 32'(fetchQ.size() == 0 || move), 32'(instrReady));
    checkValue("robAddValid", 32'(issueOcc), 32'(robAddValid));
    checkValue("rsAddValid", 32'(issueOcc && expNeedsRs), 32'(rsAddValid));
    if (leave) compareEntry();
    if (load) begin
      loadEntry(fetchQ[0], fetchPcQ[0]);
    end else if (issueOcc && !leave) begin
      if (expDep1 && cdbValid && cdbTag == expTag1) begin
        expDep1 = 1'b0;
        expVal1 = cdbValue;
      end
      if (expDep2 && cdbValid && cdbTag == expTag2) begin
        expDep2 = 1'b0;
        expVal2 = cdbValue;
      end
    end
    issueOcc = load || (issueOcc && !leave);
    if (move) begin
      void'(fetchQ.pop_front());
      void'(fetchPcQ.pop_front());
    end
    if (instrValid && instrReady) begin
      fetchQ.push_back(instrData);
      fetchPcQ.push_back(pcModel);
      void'(progQ.pop_front());
      pcModel       = pcModel + 32'd4;
      fetchAccepted = 1'b1;
    end
  endtask

  task automatic driveInputs();
    regIdx_t r;
    if (!instrValid || fetchAccepted) begin  // Hold the offer until it is taken
      instrValid = progQ.size() != 0 && ($urandom % 5) != 0;
      instrData  = instrValid ? progQ[0] : word_t'($urandom);
    end
    fetchAccepted = 1'b0;
    robAllocReady = ($urandom % 4) != 0;
    rsAddReady    = ($urandom % 4) != 0;
    robNext       = tag_t'($urandom);
    r             = regIdx_t'($urandom % 31 + 1);
    regDirty[r]   = ($urandom % 2) != 0;
    regTag[r]     = tag_t'($urandom);
    regValue[r]   = $urandom;
    src1Dirty     = regDirty[srcIdx1];
    src1Tag       = regTag[srcIdx1];
    src1Value     = regValue[srcIdx1];
    src2Dirty     = regDirty[srcIdx2];
    src2Tag       = regTag[srcIdx2];
    src2Value     = regValue[srcIdx2];
    cdbValid      = ($urandom % 4) != 0;
    case ($urandom % 4)
      0:       cdbTag = src1Tag;                      // Same-cycle bypass on source 1
      1:       cdbTag = src2Tag;                      // Same-cycle bypass on source 2
      2:       cdbTag = expDep1 ? expTag1 : expTag2;  // Wake a waiting operand
      default: cdbTag = tag_t'($urandom);
    endcase
    cdbValue = $urandom;
  endtask

  always @(posedge clockIn) begin
    if (arstN) stepModel();
  end

  initial begin
    repeat (NUM_INSTR * 20) @(posedge clockIn);
    $display("Timeout: not every instruction left the issue stage in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(14929));
    clockIn = 1'b0;
    arstN = 1'b1;
    instrValid = 1'b0;
    instrData = '0;
    robAllocReady = 1'b0;
    rsAddReady = 1'b0;
    robNext = '0;
    cdbValid = 1'b0;
    cdbTag = '0;
    cdbValue = '0;
    src1Dirty = 1'b0;
    src1Tag = '0;
    src1Value = '0;
    src2Dirty = 1'b0;
    src2Tag = '0;
    src2Value = '0;
    regDirty = '{default: 1'b0};
    regTag = '{default: '0};
    regValue = '{default: '0};
    pcModel = `RESET_PC;
    fetchAccepted = 1'b0;
    issueOcc = 1'b0;
    expectedIssues = 0;
    issuedCount = 0;
    errorCount = 0;
    buildProgram();
    #10 arstN = 1'b0;
    repeat (4) @(posedge clockIn);
    @(negedge clockIn);
    arstN = 1'b1;
    while (issuedCount < expectedIssues) begin
      @(negedge clockIn);
      driveInputs();
    end
    totalErrors = errorCount + issueUnit_inst.issueUnitProps_inst.propFailCount;
    $display("Issued %0d entries, %0d check errors, %0d assertion errors", issuedCount,
      errorCount, issueUnit_inst.issueUnitProps_inst.propFailCount);
    if (totalErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
design/issuePkg.sv
design/fetchControl.sv
design/instrDecoder.sv
design/operandResolver.sv
design/issueUnit.sv
test/issueUnit_props.sv
test/issueUnitTb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module issueUnitTb -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VissueUnitTb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
